// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_decode_stage
FILELIST  := decode_stage.f
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qxF "=== PASS ===" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/id_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface id_ctrl_if;
	import mips_id_pkg::*;

	logic      beq, bne, j, jr;
	aluop_t    alu_op;
	logic      imm_sign, src_imm, lui, link;
	logic      mem_we, mem_rd;
	res_src_t  res_src;
	reg_addr_t dreg, rega, regb;
	logic      wb_we, syscall, unknown, alu_ovf, eret;
	logic      cp0_we;
	reg_addr_t cp0_reg;

	modport dec (
		output beq, bne, j, jr, alu_op, imm_sign, src_imm, lui, link,
		output mem_we, mem_rd, res_src, dreg, rega, regb,
		output wb_we, syscall, unknown, alu_ovf, eret, cp0_we, cp0_reg
	);

	modport haz (input rega, regb, beq, bne, jr);

	modport br (input beq, bne, j, jr, link);

	modport mon (
		input beq, bne, j, jr, alu_op, imm_sign, src_imm, lui, link,
		input mem_we, mem_rd, res_src, dreg, rega, regb,
		input wb_we, syscall, unknown, alu_ovf, eret, cp0_we, cp0_reg
	);

endinterface

`default_nettype wire

// File: common/mips_id_pkg.sv
`default_nettype none

package mips_id_pkg;

	////////////////////
	// widths and types
	localparam int WORD_W   = 32;
	localparam int NUM_REGS = 32;
	localparam int REG_W    = $clog2(NUM_REGS);

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0]  reg_addr_t;
	typedef logic [3:0]        aluop_t;
	typedef logic [2:0]        res_src_t;
	typedef logic [5:0]        opcode_t;
	typedef logic [5:0]        funct_t;

	localparam reg_addr_t RA_REG = reg_addr_t'(31); // link register

	////////////////////
	// alu operation codes
	localparam aluop_t ALU_AND = 4'd0;
	localparam aluop_t ALU_OR  = 4'd1;
	localparam aluop_t ALU_ADD = 4'd2;
	localparam aluop_t ALU_XOR = 4'd3;
	localparam aluop_t ALU_NOR = 4'd4;
	localparam aluop_t ALU_SRL = 4'd5;
	localparam aluop_t ALU_SUB = 4'd6;
	localparam aluop_t ALU_SLT = 4'd7;
	localparam aluop_t ALU_SLL = 4'd8;

	// result source select for writeback
	localparam res_src_t RES_NONE = 3'd0;
	localparam res_src_t RES_ALU  = 3'd1;
	localparam res_src_t RES_CP0  = 3'd2;
	localparam res_src_t RES_HILO = 3'd3; // hi/lo or multiplier

	////////////////////
	// opcodes
	localparam opcode_t OP_RTYPE    = 6'h00;
	localparam opcode_t OP_J        = 6'h02;
	localparam opcode_t OP_JAL      = 6'h03;
	localparam opcode_t OP_BEQ      = 6'h04;
	localparam opcode_t OP_BNE      = 6'h05;
	localparam opcode_t OP_ADDI     = 6'h08;
	localparam opcode_t OP_ADDIU    = 6'h09;
	localparam opcode_t OP_SLTI     = 6'h0a;
	localparam opcode_t OP_ANDI     = 6'h0c;
	localparam opcode_t OP_ORI      = 6'h0d;
	localparam opcode_t OP_XORI     = 6'h0e;
	localparam opcode_t OP_LUI      = 6'h0f;
	localparam opcode_t OP_COP0     = 6'h10;
	localparam opcode_t OP_SPECIAL2 = 6'h1c;
	localparam opcode_t OP_LW       = 6'h23;
	localparam opcode_t OP_SW       = 6'h2b;

	////////////////////
	// function codes, r-type
	localparam funct_t FN_SLL     = 6'h00;
	localparam funct_t FN_SRL     = 6'h02;
	localparam funct_t FN_JR      = 6'h08;
	localparam funct_t FN_JALR    = 6'h09;
	localparam funct_t FN_SYSCALL = 6'h0c;
	localparam funct_t FN_MFHI    = 6'h10;
	localparam funct_t FN_MTHI    = 6'h11;
	localparam funct_t FN_MFLO    = 6'h12;
	localparam funct_t FN_MTLO    = 6'h13;
	localparam funct_t FN_MULT    = 6'h18;
	localparam funct_t FN_MULTU   = 6'h19;
	localparam funct_t FN_ADD     = 6'h20;
	localparam funct_t FN_ADDU    = 6'h21;
	localparam funct_t FN_SUB     = 6'h22;
	localparam funct_t FN_SUBU    = 6'h23;
	localparam funct_t FN_AND     = 6'h24;
	localparam funct_t FN_OR      = 6'h25;
	localparam funct_t FN_XOR     = 6'h26;
	localparam funct_t FN_NOR     = 6'h27;
	localparam funct_t FN_SLT     = 6'h2a;

	// special2 group
	localparam funct_t FN_MADD  = 6'h00;
	localparam funct_t FN_MADDU = 6'h01;
	localparam funct_t FN_MUL   = 6'h02;
	localparam funct_t FN_MSUB  = 6'h04;
	localparam funct_t FN_MSUBU = 6'h05;

	// cop0 forms
	localparam word_t     ERET_WORD = 32'h4200_0018;
	localparam reg_addr_t CP0_RS_MF = 5'd0;
	localparam reg_addr_t CP0_RS_MT = 5'd4;

endpackage

`default_nettype wire

// File: decode/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	id_ctrl_if.haz             ctrl,
	input  mips_id_pkg::reg_addr_t ex_dreg,
	input  logic               ex_wb_we,
	input  logic               ex_mem_rd,
	output logic               stall
);
	import mips_id_pkg::*;

	logic ex_live;   // execute writes a real register
	logic src_match; // ex_dreg is one of our sources
	logic br_reads;
	logic load_use;
	logic branch_use;

	assign ex_live   = (ex_dreg != '0);
	assign src_match = (ex_dreg == ctrl.rega) || (ex_dreg == ctrl.regb);
	assign br_reads  = ctrl.beq | ctrl.bne | ctrl.jr;

	////////////////////
	// load-use, data not ready until mem
	assign load_use = ex_mem_rd && src_match;

	// branches resolve in decode, so any pending alu write blocks them
	assign branch_use = ex_wb_we && br_reads && src_match;

	assign stall = ex_live && (load_use || branch_use);

endmodule

`default_nettype wire

// File: decode/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  mips_id_pkg::word_t inst,
	id_ctrl_if.dec             ctrl
);
	import mips_id_pkg::*;

	opcode_t   op;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	reg_addr_t shamt;
	funct_t    funct;

	assign {op, rs, rt, rd, shamt, funct} = inst;

	// alu code for the register-register and shift forms
	function automatic aluop_t funct_alu(funct_t f);
		case (f)
			FN_ADD, FN_ADDU: funct_alu = ALU_ADD;
			FN_SUB, FN_SUBU: funct_alu = ALU_SUB;
			FN_SLT:          funct_alu = ALU_SLT;
			FN_AND:          funct_alu = ALU_AND;
			FN_OR:           funct_alu = ALU_OR;
			FN_XOR:          funct_alu = ALU_XOR;
			FN_NOR:          funct_alu = ALU_NOR;
			FN_SRL:          funct_alu = ALU_SRL;
			default:         funct_alu = ALU_SLL;
		endcase
	endfunction

	always_comb begin
		ctrl.beq      = 1'b0;
		ctrl.bne      = 1'b0;
		ctrl.j        = 1'b0;
		ctrl.jr       = 1'b0;
		ctrl.alu_op   = ALU_AND;
		ctrl.imm_sign = 1'b0;
		ctrl.src_imm  = 1'b0;
		ctrl.lui      = 1'b0;
		ctrl.link     = 1'b0;
		ctrl.mem_we   = 1'b0;
		ctrl.mem_rd   = 1'b0;
		ctrl.res_src  = RES_NONE;
		ctrl.dreg     = '0;
		ctrl.rega     = '0; // unused fields stay 0, never hazard
		ctrl.regb     = '0;
		ctrl.wb_we    = 1'b0;
		ctrl.syscall  = 1'b0;
		ctrl.unknown  = 1'b0;
		ctrl.alu_ovf  = 1'b0;
		ctrl.eret     = 1'b0;
		ctrl.cp0_we   = 1'b0;
		ctrl.cp0_reg  = '0;

		if (inst != '0) begin // all-zero word is the nop
			case (op)
				OP_RTYPE: begin
					case (funct)
						FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT,
						FN_AND, FN_OR, FN_XOR, FN_NOR: begin
							ctrl.alu_op  = funct_alu(funct);
							ctrl.alu_ovf = (funct == FN_ADD) || (funct == FN_SUB); // trapping forms
							ctrl.res_src = RES_ALU;
							ctrl.wb_we   = 1'b1;
							ctrl.dreg    = rd;
							ctrl.rega    = rs;
							ctrl.regb    = rt;
						end
						FN_SLL, FN_SRL: begin
							ctrl.alu_op  = funct_alu(funct);
							ctrl.src_imm = 1'b1; // shamt as operand b
							ctrl.res_src = RES_ALU;
							ctrl.wb_we   = 1'b1;
							ctrl.dreg    = rd;
							ctrl.rega    = rt;
						end
						FN_JR: begin
							ctrl.jr   = 1'b1;
							ctrl.rega = rs;
						end
						FN_JALR: begin
							ctrl.jr      = 1'b1;
							ctrl.link    = 1'b1;
							ctrl.rega    = rs;
							ctrl.res_src = RES_ALU;
							ctrl.wb_we   = 1'b1;
							ctrl.dreg    = RA_REG;
						end
						FN_SYSCALL: ctrl.syscall = 1'b1;
						FN_MFHI, FN_MFLO: begin
							ctrl.res_src = RES_HILO;
							ctrl.wb_we   = 1'b1;
							ctrl.dreg    = rd;
						end
						FN_MTHI, FN_MTLO: ctrl.rega = rs;
						FN_MULT, FN_MULTU: begin
							ctrl.rega = rs;
							ctrl.regb = rt;
						end
						default: ctrl.unknown = 1'b1;
					endcase
				end
				OP_LW, OP_SW: begin
					ctrl.alu_op   = ALU_ADD; // address = rs + simm
					ctrl.imm_sign = 1'b1;
					ctrl.src_imm  = 1'b1;
					ctrl.rega     = rs;
					ctrl.mem_rd   = (op == OP_LW);
					ctrl.mem_we   = (op == OP_SW);
					ctrl.wb_we    = (op == OP_LW);
					ctrl.dreg     = (op == OP_LW) ? rt : '0;
					ctrl.regb     = (op == OP_SW) ? rt : '0; // store data
				end
				OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: begin
					ctrl.alu_op   = (op == OP_ANDI) ? ALU_AND :
					                (op == OP_ORI)  ? ALU_OR  :
					                (op == OP_XORI) ? ALU_XOR :
					                (op == OP_SLTI) ? ALU_SLT : ALU_ADD;
					ctrl.imm_sign = (op == OP_ADDI) || (op == OP_ADDIU) || (op == OP_SLTI);
					ctrl.alu_ovf  = (op == OP_ADDI);
					ctrl.src_imm  = 1'b1;
					ctrl.res_src  = RES_ALU;
					ctrl.wb_we    = 1'b1;
					ctrl.dreg     = rt;
					ctrl.rega     = rs;
				end
				OP_LUI: begin
					ctrl.src_imm = 1'b1;
					ctrl.lui     = 1'b1;
					ctrl.res_src = RES_ALU;
					ctrl.wb_we   = 1'b1;
					ctrl.dreg    = rt;
				end
				OP_BEQ, OP_BNE: begin
					ctrl.beq  = (op == OP_BEQ);
					ctrl.bne  = (op == OP_BNE);
					ctrl.rega = rs;
					ctrl.regb = rt;
				end
				OP_J: ctrl.j = 1'b1;
				OP_JAL: begin
					ctrl.j       = 1'b1;
					ctrl.link    = 1'b1;
					ctrl.res_src = RES_ALU;
					ctrl.wb_we   = 1'b1;
					ctrl.dreg    = RA_REG;
				end
				OP_COP0: begin
					if (inst == ERET_WORD) begin
						ctrl.eret = 1'b1;
					end else if (rs == CP0_RS_MF && inst[10:3] == '0) begin // mfc0
						ctrl.cp0_reg = rd;
						ctrl.res_src = RES_CP0;
						ctrl.wb_we   = 1'b1;
						ctrl.dreg    = rt;
					end else if (rs == CP0_RS_MT && inst[10:3] == '0) begin // mtc0
						ctrl.cp0_we  = 1'b1;
						ctrl.cp0_reg = rd;
						ctrl.regb    = rt;
					end else begin
						ctrl.unknown = 1'b1;
					end
				end
				OP_SPECIAL2: begin
					if (shamt == '0 && funct == FN_MUL) begin
						ctrl.res_src = RES_HILO;
						ctrl.wb_we   = 1'b1;
						ctrl.dreg    = rd;
						ctrl.rega    = rs;
						ctrl.regb    = rt;
					end else if (shamt == '0 && rd == '0 &&
					             funct inside {FN_MADD, FN_MADDU, FN_MSUB, FN_MSUBU}) begin
						ctrl.rega = rs; // accumulate into hi/lo
						ctrl.regb = rt;
					end else begin
						ctrl.unknown = 1'b1;
					end
				end
				default: ctrl.unknown = 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: decode_stage.f
common/mips_id_pkg.sv
common/id_ctrl_if.sv
decode/inst_decoder.sv
decode/hazard_unit.sv
logic/reg_file.sv
logic/branch_resolver.sv
logic/decode_stage.sv
tests/decode_stage_sva.sv
tests/tb_decode_stage.sv

// File: logic/branch_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolver (
	id_ctrl_if.br              ctrl,
	input  mips_id_pkg::word_t pc_plus4,
	input  logic [25:0]        inst_index,
	input  mips_id_pkg::word_t opnd_a,
	input  mips_id_pkg::word_t opnd_b,
	input  logic               stall,
	output logic               taken,
	output mips_id_pkg::word_t target,
	output mips_id_pkg::word_t link_addr
);
	import mips_id_pkg::*;

	word_t br_off;
	word_t br_target;
	word_t jmp_target;
	logic  equal;
	logic  cond;

	assign br_off     = {{14{inst_index[15]}}, inst_index[15:0], 2'b00}; // simm << 2
	assign br_target  = pc_plus4 + br_off;
	assign jmp_target = {pc_plus4[31:28], inst_index, 2'b00}; // pseudo-direct
	assign equal      = (opnd_a == opnd_b);

	////////////////////
	// direction and target
	always_comb begin
		cond   = 1'b0;
		target = pc_plus4; // fall through
		if (ctrl.beq || ctrl.bne) begin
			cond   = ctrl.beq ? equal : !equal;
			target = br_target;
		end else if (ctrl.j) begin
			cond   = 1'b1;
			target = jmp_target;
		end else if (ctrl.jr) begin
			cond   = 1'b1;
			target = opnd_a;
		end
	end

	assign taken     = cond && !stall; // held off while operands pending
	assign link_addr = ctrl.link ? pc_plus4 + word_t'(4) : '0; // skip delay slot

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                   clk,
	input  logic                   arst_n,
	input  mips_id_pkg::word_t     inst,
	input  mips_id_pkg::word_t     pc_plus4,
	input  logic                   wb_we,
	input  mips_id_pkg::reg_addr_t wb_dreg,
	input  mips_id_pkg::word_t     wb_data,
	input  mips_id_pkg::reg_addr_t ex_dreg,
	input  logic                   ex_wb_we,
	input  logic                   ex_mem_rd,
	output logic                   beq, bne, jump, jr,
	output mips_id_pkg::aluop_t    alu_op,
	output logic                   imm_sign, src_imm, lui, link,
	output logic                   mem_we, mem_rd,
	output mips_id_pkg::res_src_t  res_src,
	output mips_id_pkg::reg_addr_t dreg, rega, regb,
	output logic                   wb_en, syscall, unknown, alu_ovf, eret,
	output logic                   cp0_we,
	output mips_id_pkg::reg_addr_t cp0_reg,
	output mips_id_pkg::word_t     rega_data, regb_data,
	output logic                   stall,
	output logic                   branch_taken,
	output mips_id_pkg::word_t     branch_target,
	output mips_id_pkg::word_t     link_addr
);
	import mips_id_pkg::*;

	id_ctrl_if ctrl_bus ();

	inst_decoder u_decoder (
		.inst (inst),
		.ctrl (ctrl_bus.dec)
	);

	reg_file u_reg_file (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_addr_a (ctrl_bus.rega),
		.rd_addr_b (ctrl_bus.regb),
		.rd_data_a (rega_data),
		.rd_data_b (regb_data),
		.wr_en     (wb_we),
		.wr_addr   (wb_dreg),
		.wr_data   (wb_data)
	);

	hazard_unit u_hazard (
		.ctrl      (ctrl_bus.haz),
		.ex_dreg   (ex_dreg),
		.ex_wb_we  (ex_wb_we),
		.ex_mem_rd (ex_mem_rd),
		.stall     (stall)
	);

	branch_resolver u_branch (
		.ctrl       (ctrl_bus.br),
		.pc_plus4   (pc_plus4),
		.inst_index (inst[25:0]),
		.opnd_a     (rega_data),
		.opnd_b     (regb_data),
		.stall      (stall),
		.taken      (branch_taken),
		.target     (branch_target),
		.link_addr  (link_addr)
	);

	////////////////////
	// control bundle out to ports
	assign beq      = ctrl_bus.beq;
	assign bne      = ctrl_bus.bne;
	assign jump     = ctrl_bus.j;
	assign jr       = ctrl_bus.jr;
	assign alu_op   = ctrl_bus.alu_op;
	assign imm_sign = ctrl_bus.imm_sign;
	assign src_imm  = ctrl_bus.src_imm;
	assign lui      = ctrl_bus.lui;
	assign link     = ctrl_bus.link;
	assign mem_we   = ctrl_bus.mem_we;
	assign mem_rd   = ctrl_bus.mem_rd;
	assign res_src  = ctrl_bus.res_src;
	assign dreg     = ctrl_bus.dreg;
	assign rega     = ctrl_bus.rega;
	assign regb     = ctrl_bus.regb;
	assign wb_en    = ctrl_bus.wb_we; // write enable for this instruction
	assign syscall  = ctrl_bus.syscall;
	assign unknown  = ctrl_bus.unknown;
	assign alu_ovf  = ctrl_bus.alu_ovf;
	assign eret     = ctrl_bus.eret;
	assign cp0_we   = ctrl_bus.cp0_we;
	assign cp0_reg  = ctrl_bus.cp0_reg;

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                   clk,
	input  logic                   arst_n,
	input  mips_id_pkg::reg_addr_t rd_addr_a,
	input  mips_id_pkg::reg_addr_t rd_addr_b,
	output mips_id_pkg::word_t     rd_data_a,
	output mips_id_pkg::word_t     rd_data_b,
	input  logic                   wr_en,
	input  mips_id_pkg::reg_addr_t wr_addr,
	input  mips_id_pkg::word_t     wr_data
);
	import mips_id_pkg::*;

	word_t regs [NUM_REGS];

	// zero register, then same-cycle bypass, then storage
	function automatic word_t read_port(reg_addr_t addr);
		if (addr == '0)
			read_port = '0;
		else if (wr_en && addr == wr_addr)
			read_port = wr_data;
		else
			read_port = regs[addr];
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data; // r0 stays zero
		end
	end

	always_comb begin
		rd_data_a = read_port(rd_addr_a);
		rd_data_b = read_port(rd_addr_b);
	end

endmodule

`default_nettype wire

// File: tests/decode_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_sva (
	input logic                   clk,
	input logic                   arst_n,
	input mips_id_pkg::word_t     inst,
	input logic                   stall,
	input logic                   branch_taken,
	input logic                   unknown,
	input logic                   wb_en,
	input logic                   mem_we,
	input mips_id_pkg::reg_addr_t rega,
	input mips_id_pkg::reg_addr_t regb,
	input mips_id_pkg::word_t     rega_data,
	input mips_id_pkg::word_t     regb_data,
	input logic [42:0]            ctrl_bits
);

	int unsigned fail_count = 0; // read by the testbench summary

	a_stall_blocks_branch: assert property (@(posedge clk) disable iff (!arst_n)
		stall |-> !branch_taken)
		else begin
			fail_count++;
			$error("branch taken while stall is high");
		end

	a_unknown_is_inert: assert property (@(posedge clk) disable iff (!arst_n)
		unknown |-> (!wb_en && !mem_we))
		else begin
			fail_count++;
			$error("unknown instruction enables a write");
		end

	// r0 reads zero on both ports
	a_zero_reg: assert property (@(posedge clk) disable iff (!arst_n)
		(rega != '0 || rega_data == '0) && (regb != '0 || regb_data == '0))
		else begin
			fail_count++;
			$error("register 0 read a non-zero value");
		end

	a_idle_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
		($past(arst_n) && !$past(arst_n, 2) && inst == '0) |-> (ctrl_bits == '0))
		else begin
			fail_count++;
			$error("control outputs active after reset with a zero word");
		end

endmodule

bind decode_stage decode_stage_sva sva0 (
	.clk          (clk),
	.arst_n       (arst_n),
	.inst         (inst),
	.stall        (stall),
	.branch_taken (branch_taken),
	.unknown      (unknown),
	.wb_en        (wb_en),
	.mem_we       (mem_we),
	.rega         (rega),
	.regb         (regb),
	.rega_data    (rega_data),
	.regb_data    (regb_data),
	.ctrl_bits    ({beq, bne, jump, jr, alu_op, imm_sign, src_imm, lui, link, mem_we, mem_rd,
	                res_src, dreg, rega, regb, wb_en, syscall, unknown, alu_ovf, eret,
	                cp0_we, cp0_reg})
);

`default_nettype wire

// File: tests/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;
	import mips_id_pkg::*;

	localparam int unsigned SEED = 32'h9ae2_8f79;
	localparam int RST_CYCLES = 3;
	localparam int N_RST = 16;
	localparam int N_DEC = 300;
	localparam int N_RF  = 120;
	localparam int N_ST  = 150;
	localparam int N_BR  = 120;
	localparam int N_SUP = 40;
	localparam int TOTAL_CYCLES = RST_CYCLES + 2 + N_RST + N_DEC + N_RF + N_ST + 8 + N_BR
	                              + 2 * N_SUP;
	localparam int TIMEOUT_CYCLES = TOTAL_CYCLES * 3 / 2;

	localparam funct_t RTYPE_FUNCTS [20] = '{FN_SLL, FN_SRL, FN_JR, FN_JALR, FN_SYSCALL,
		FN_MFHI, FN_MTHI, FN_MFLO, FN_MTLO, FN_MULT, FN_MULTU, FN_ADD, FN_ADDU, FN_SUB,
		FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};
	localparam opcode_t IMM_OPS [9] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI,
		OP_XORI, OP_LUI, OP_LW, OP_SW};
	localparam opcode_t BR_OPS [4] = '{OP_BEQ, OP_BNE, OP_J, OP_JAL};
	localparam funct_t SP2_FUNCTS [5] = '{FN_MADD, FN_MADDU, FN_MUL, FN_MSUB, FN_MSUBU};

	// expected control bundle, same order as the DUT ports
	typedef struct packed {
		logic      beq, bne, jump, jr;
		aluop_t    alu_op;
		logic      imm_sign, src_imm, lui, link, mem_we, mem_rd;
		res_src_t  res_src;
		reg_addr_t dreg, rega, regb;
		logic      wb_en, syscall, unknown, alu_ovf, eret, cp0_we;
		reg_addr_t cp0_reg;
	} ctrl_t;

	logic      clk, arst_n;
	word_t     inst, pc_plus4, wb_data;
	logic      wb_we, ex_wb_we, ex_mem_rd;
	reg_addr_t wb_dreg, ex_dreg;
	logic      beq, bne, jump, jr, imm_sign, src_imm, lui, link, mem_we, mem_rd;
	aluop_t    alu_op;
	res_src_t  res_src;
	reg_addr_t dreg, rega, regb, cp0_reg;
	logic      wb_en, syscall, unknown, alu_ovf, eret, cp0_we;
	word_t     rega_data, regb_data, branch_target, link_addr;
	logic      stall, branch_taken;
	ctrl_t     dut_ctrl;

	word_t model_regs [NUM_REGS]; // architectural state as the model sees it
	int    checks, errors, tests, cycles;
	int    base_checks, base_errors;
	string test_name;
	logic  last_stall, last_taken;

	decode_stage dut0 (.*);

	assign dut_ctrl = {beq, bne, jump, jr, alu_op, imm_sign, src_imm, lui, link, mem_we, mem_rd,
		res_src, dreg, rega, regb, wb_en, syscall, unknown, alu_ovf, eret, cp0_we, cp0_reg};

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////
	// compare tasks
	task automatic check_ctrl(ctrl_t got, ctrl_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error @ %0t: control for inst %h got %h exp %h", $time, inst, got, exp);
		end
	endtask

	task automatic check_word(string what, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error @ %0t: %s got %h exp %h (inst %h)", $time, what, got, exp, inst);
		end
	endtask

	task automatic check_flag(string what, logic got, bit exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error @ %0t: %s got %b exp %b (inst %h)", $time, what, got, exp, inst);
		end
	endtask

	////////////////////
	// reference model
	function automatic ctrl_t expected_ctrl(word_t w);
		ctrl_t     e;
		opcode_t   op;
		reg_addr_t rs, rt, rd, sa;
		funct_t    fn;
		e = '0;
		{op, rs, rt, rd, sa, fn} = w;
		if (w == '0)
			return e; // nop
		case (op)
			OP_RTYPE: begin
				case (fn)
					FN_ADD, FN_ADDU: e.alu_op = ALU_ADD;
					FN_SUB, FN_SUBU: e.alu_op = ALU_SUB;
					FN_SLT:          e.alu_op = ALU_SLT;
					FN_OR:           e.alu_op = ALU_OR;
					FN_XOR:          e.alu_op = ALU_XOR;
					FN_NOR:          e.alu_op = ALU_NOR;
					FN_SLL:          e.alu_op = ALU_SLL;
					FN_SRL:          e.alu_op = ALU_SRL;
					default:         e.alu_op = ALU_AND;
				endcase
				case (fn)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_AND, FN_OR, FN_XOR, FN_NOR: begin
						e.alu_ovf = (fn == FN_ADD) || (fn == FN_SUB);
						{e.res_src, e.wb_en, e.dreg, e.rega, e.regb} = {RES_ALU, 1'b1, rd, rs, rt};
					end
					FN_SLL, FN_SRL: begin
						e.src_imm = 1'b1; // shift amount
						{e.res_src, e.wb_en, e.dreg, e.rega} = {RES_ALU, 1'b1, rd, rt};
					end
					FN_JR:   {e.jr, e.rega} = {1'b1, rs};
					FN_JALR: begin
						{e.jr, e.link, e.rega} = {1'b1, 1'b1, rs};
						{e.res_src, e.wb_en, e.dreg} = {RES_ALU, 1'b1, RA_REG};
					end
					FN_SYSCALL:        e.syscall = 1'b1;
					FN_MFHI, FN_MFLO:  {e.res_src, e.wb_en, e.dreg} = {RES_HILO, 1'b1, rd};
					FN_MTHI, FN_MTLO:  e.rega = rs;
					FN_MULT, FN_MULTU: {e.rega, e.regb} = {rs, rt};
					default:           e = '{unknown: 1'b1, default: '0};
				endcase
			end
			OP_LW, OP_SW: begin
				{e.alu_op, e.imm_sign, e.src_imm, e.rega} = {ALU_ADD, 1'b1, 1'b1, rs};
				if (op == OP_LW)
					{e.mem_rd, e.wb_en, e.dreg} = {1'b1, 1'b1, rt};
				else
					{e.mem_we, e.regb} = {1'b1, rt}; // store data
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: begin
				case (op)
					OP_ANDI: e.alu_op = ALU_AND;
					OP_ORI:  e.alu_op = ALU_OR;
					OP_XORI: e.alu_op = ALU_XOR;
					OP_SLTI: e.alu_op = ALU_SLT;
					default: e.alu_op = ALU_ADD;
				endcase
				e.imm_sign = (op == OP_ADDI) || (op == OP_ADDIU) || (op == OP_SLTI);
				e.alu_ovf  = (op == OP_ADDI);
				e.src_imm  = 1'b1;
				{e.res_src, e.wb_en, e.dreg, e.rega} = {RES_ALU, 1'b1, rt, rs};
			end
			OP_LUI: begin
				{e.src_imm, e.lui} = 2'b11;
				{e.res_src, e.wb_en, e.dreg} = {RES_ALU, 1'b1, rt};
			end
			OP_BEQ, OP_BNE: begin
				{e.beq, e.bne} = {op == OP_BEQ, op == OP_BNE};
				{e.rega, e.regb} = {rs, rt};
			end
			OP_J:   e.jump = 1'b1;
			OP_JAL: begin
				{e.jump, e.link} = 2'b11;
				{e.res_src, e.wb_en, e.dreg} = {RES_ALU, 1'b1, RA_REG};
			end
			OP_COP0: begin
				if (w == ERET_WORD)
					e.eret = 1'b1;
				else if (rs == CP0_RS_MF && w[10:3] == '0)
					{e.cp0_reg, e.res_src, e.wb_en, e.dreg} = {rd, RES_CP0, 1'b1, rt};
				else if (rs == CP0_RS_MT && w[10:3] == '0)
					{e.cp0_we, e.cp0_reg, e.regb} = {1'b1, rd, rt};
				else
					e.unknown = 1'b1;
			end
			OP_SPECIAL2: begin
				if (sa == '0 && fn == FN_MUL) begin
					{e.res_src, e.wb_en, e.dreg} = {RES_HILO, 1'b1, rd};
					{e.rega, e.regb} = {rs, rt};
				end else if (sa == '0 && rd == '0 &&
				             fn inside {FN_MADD, FN_MADDU, FN_MSUB, FN_MSUBU})
					{e.rega, e.regb} = {rs, rt}; // hi/lo accumulate
				else
					e.unknown = 1'b1;
			end
			default: e.unknown = 1'b1;
		endcase
		return e;
	endfunction

	// zero register, same-cycle write, stored value
	function automatic word_t expected_read(reg_addr_t a);
		if (a == '0)
			return '0;
		if (wb_we && wb_dreg == a)
			return wb_data;
		return model_regs[a];
	endfunction

	////////////////////
	// stimulus
	function automatic word_t random_pc();
		return $urandom & 32'hffff_fffc;
	endfunction

	function automatic word_t random_inst();
		int     pick;
		funct_t fn;
		word_t  w;
		pick = $urandom_range(99);
		fn   = SP2_FUNCTS[$urandom_range(4)];
		w    = $urandom;
		if (pick < 5)
			w = '0;
		else if (pick < 35)
			w = {OP_RTYPE, w[25:6], RTYPE_FUNCTS[$urandom_range(19)]};
		else if (pick < 60)
			w[31:26] = IMM_OPS[$urandom_range(8)];
		else if (pick < 70)
			w[31:26] = BR_OPS[$urandom_range(3)];
		else if (pick < 73)
			w = ERET_WORD;
		else if (pick < 80)
			w = {OP_COP0, pick[0] ? CP0_RS_MT : CP0_RS_MF, w[20:11], 8'h00, w[2:0]};
		else if (pick < 88)
			w = {OP_SPECIAL2, w[25:16], w[15:11] & {5{fn == FN_MUL}}, 5'd0, fn};
		return w; // the rest stay raw, mostly illegal
	endfunction

	// operands come from the preloaded r1..r8
	function automatic word_t branch_inst(int kind);
		reg_addr_t rs;
		reg_addr_t rt;
		word_t     w;
		rs = reg_addr_t'($urandom_range(8, 1));
		rt = reg_addr_t'($urandom_range(8, 1));
		w  = $urandom;
		case (kind)
			0:       w = {OP_BEQ, rs, rt, w[15:0]};
			1:       w = {OP_BNE, rs, rt, w[15:0]};
			2:       w[31:26] = OP_J;
			3:       w[31:26] = OP_JAL;
			4:       w = {OP_RTYPE, rs, 15'd0, FN_JR};
			default: w = {OP_RTYPE, rs, 5'd0, RA_REG, 5'd0, FN_JALR};
		endcase
		return w;
	endfunction

	task automatic drive_and_check(word_t w, word_t pc4, logic wwe, reg_addr_t wd, word_t wdat,
	                               reg_addr_t exd, logic exw, logic exm);
		ctrl_t e;
		word_t a, b, tgt;
		logic  st, cond;
		#2;
		inst      = w;
		pc_plus4  = pc4;
		wb_we     = wwe;
		wb_dreg   = wd;
		wb_data   = wdat;
		ex_dreg   = exd;
		ex_wb_we  = exw;
		ex_mem_rd = exm;
		#18; // mid-cycle, outputs settled
		e  = expected_ctrl(w);
		a  = expected_read(e.rega);
		b  = expected_read(e.regb);
		st = (exd != '0) && (exd == e.rega || exd == e.regb)
		     && (exm || (exw && (e.beq || e.bne || e.jr)));
		cond = 1'b0;
		tgt  = pc4;
		if (e.beq || e.bne) begin
			cond = e.beq ? (a == b) : (a != b);
			tgt  = pc4 + {{14{w[15]}}, w[15:0], 2'b00};
		end else if (e.jump) begin
			cond = 1'b1;
			tgt  = {pc4[31:28], w[25:0], 2'b00};
		end else if (e.jr) begin
			cond = 1'b1;
			tgt  = a;
		end
		last_stall = stall;
		last_taken = branch_taken;
		check_ctrl(dut_ctrl, e);
		check_word("rega_data", rega_data, a);
		check_word("regb_data", regb_data, b);
		check_flag("stall", stall, st);
		check_flag("branch_taken", branch_taken, cond && !st);
		check_word("branch_target", branch_target, tgt);
		check_word("link_addr", link_addr, e.link ? pc4 + 32'd4 : '0);
		@(posedge clk);
		if (wwe && wd != '0)
			model_regs[wd] = wdat; // write lands at this edge
	endtask

	task automatic open_test(string name);
		test_name   = name;
		base_checks = checks;
		base_errors = errors;
	endtask

	task automatic report_test();
		tests++;
		$display("test %s: %0d checks, %0d errors", test_name, checks - base_checks,
			errors - base_errors);
	endtask

	initial begin
		word_t     w;
		word_t     pc;
		word_t     vals [4];
		reg_addr_t rs;
		reg_addr_t wd;
		reg_addr_t prev;
		int        k;
		void'($urandom(SEED));
		arst_n    = 1'b0;
		inst      = '0;
		pc_plus4  = '0;
		wb_we     = 1'b0;
		wb_dreg   = '0;
		wb_data   = '0;
		ex_dreg   = '0;
		ex_wb_we  = 1'b0;
		ex_mem_rd = 1'b0;
		prev      = '0;
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#2 arst_n = 1'b1;
		repeat (2) @(posedge clk); // idle cycles with a zero word

		open_test("reg_reset");
		for (int i = 0; i < N_RST; i++)
			drive_and_check({OP_RTYPE, reg_addr_t'(2 * i), reg_addr_t'(2 * i + 1), 5'd1, 5'd0,
				FN_ADDU}, random_pc(), 1'b0, '0, '0, '0, 1'b0, 1'b0);
		report_test();

		open_test("decode_table");
		for (int i = 0; i < N_DEC; i++)
			drive_and_check(random_inst(), random_pc(), 1'($urandom), reg_addr_t'($urandom),
				$urandom, reg_addr_t'($urandom), 1'($urandom), 1'($urandom));
		report_test();

		open_test("reg_file");
		for (int i = 0; i < N_RF; i++) begin
			rs = (i % 10 == 0) ? '0 : reg_addr_t'($urandom);
			wd = ($urandom_range(2) == 0) ? rs : reg_addr_t'($urandom); // bypass case
			drive_and_check({OP_RTYPE, rs, prev, 5'd3, 5'd0, FN_ADDU}, random_pc(),
				$urandom_range(3) != 0, wd, $urandom, '0, 1'b0, 1'b0);
			prev = wd; // read it back next cycle
		end
		report_test();

		open_test("stall");
		for (int i = 0; i < N_ST; i++) begin
			w  = random_inst();
			k  = $urandom_range(3);
			wd = (k == 0) ? w[25:21] : (k == 1) ? w[20:16] :
			     (k == 2) ? '0 : reg_addr_t'($urandom);
			drive_and_check(w, random_pc(), 1'b0, '0, '0, wd, 1'($urandom), 1'($urandom));
		end
		report_test();

		open_test("branch");
		for (int i = 0; i < 8; i++) begin
			if (i < 4)
				vals[i] = $urandom;
			drive_and_check('0, random_pc(), 1'b1, reg_addr_t'(i + 1), vals[i % 4], '0, 1'b0,
				1'b0); // r5..r8 mirror r1..r4
		end
		for (int i = 0; i < N_BR; i++)
			drive_and_check(branch_inst($urandom_range(5)), random_pc(), 1'b0, '0, '0, '0, 1'b0,
				1'b0);
		report_test();

		open_test("stall_suppress");
		for (int i = 0; i < N_SUP; i++) begin
			k  = $urandom_range(2);
			w  = branch_inst((k == 2) ? 4 : k);
			pc = random_pc();
			drive_and_check(w, pc, 1'b0, '0, '0, w[25:21], 1'b1, 1'b1);
			check_flag("stall with load feeding branch", last_stall, 1'b1);
			check_flag("branch held during stall", last_taken, 1'b0);
			drive_and_check(w, pc, 1'b0, '0, '0, '0, 1'b0, 1'b0);
		end
		report_test();

		errors += dut0.sva0.fail_count;
		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
